// File: logic/pcie_cfg_regmap_pkg.sv
package pcie_cfg_regmap_pkg;

    // Magic words at +000 of each region
    localparam logic [15:0] RW_MAGIC = 16'h6745;
    localparam logic [15:0] RO_MAGIC = 16'h2301;

    localparam int RW_BYTES = 14;      // Control region size
    localparam int RO_BYTES = 12;      // Status region size

    // ------------------------------
    // Control region word offsets
    // ------------------------------
    localparam int OFS_CTRL          = 'h002;
    localparam int OFS_MGMT_DI_LO    = 'h004;
    localparam int OFS_MGMT_DI_HI    = 'h006;
    localparam int OFS_MGMT_ADDR     = 'h008;
    localparam int OFS_CLR_PERIOD_LO = 'h00A;
    localparam int OFS_CLR_PERIOD_HI = 'h00C;

    localparam logic [15:0] MGMT_ADDR_RESET = 16'hF000;   // All byte enables on

    // Fields of OFS_MGMT_ADDR above the dword address
    localparam int ADDR_RDONLY_BIT = 10;
    localparam int ADDR_RW1C_BIT   = 11;
    localparam int ADDR_BE_LSB     = 12;

    // Bits of OFS_CTRL
    localparam int CTRL_RD_START      = 0;   // Write 1 to start
    localparam int CTRL_WR_START      = 1;   // Write 1 to start
    localparam int CTRL_WAIT_COMPLETE = 2;
    localparam int CTRL_STATUS_CL_EN  = 4;
    localparam int CTRL_COMMAND_EN    = 5;

    // ------------------------------
    // Status region word offsets
    // ------------------------------
    localparam int OFS_PCIE_ID    = 'h002;
    localparam int OFS_RD_INFO    = 'h004;
    localparam int OFS_RD_DATA_LO = 'h006;
    localparam int OFS_RD_DATA_HI = 'h008;
    localparam int OFS_BUSY       = 'h00A;

    // Periodic command/status register write
    localparam int          CLR_DWADDR = 1;
    localparam logic [31:0] CLR_DATA   = 32'hFF000007;

    typedef enum logic [1:0] {IDLE, READ, WRITE} mgmt_state_e;

endpackage

// File: logic/pcie_cfg_cmd_pkg.sv
package pcie_cfg_cmd_pkg;

    // Opcode in command bits 13..12, value 11 falls back to none
    typedef enum logic [1:0] {
        OP_NONE  = 2'b00,
        OP_READ  = 2'b01,
        OP_WRITE = 2'b10
    } cmd_op_e;

    // ------------------------------
    // Command word, 64 bits
    // ------------------------------
    localparam int CMD_OP_LSB    = 12;
    localparam int CMD_ADDR_LSB  = 16;
    localparam int CMD_MASK_LSB  = 32;
    localparam int CMD_VALUE_LSB = 48;

    localparam int ADDR_RW_BIT = 15;   // Set selects the control region

    // ------------------------------
    // Response word, 32 bits
    // ------------------------------
    localparam int RSP_DATA_LSB = 0;
    localparam int RSP_ADDR_LSB = 16;

endpackage

// File: logic/cfg_cmd_decoder.sv
module cfg_cmd_decoder (
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        i_cmd_valid,
    input  logic [63:0] i_cmd_data,
    output logic        o_cmd_ready,
    output logic        o_rsp_valid,
    output logic [31:0] o_rsp_data,
    input  logic        i_rsp_ready,
    output logic        o_reg_wr,
    output logic [15:0] o_reg_addr,
    output logic [15:0] o_reg_mask,
    output logic [15:0] o_reg_value,
    input  logic [15:0] i_reg_rdata,
    input  logic        i_wait_complete,
    input  logic        i_seq_busy
);

    pcie_cfg_cmd_pkg::cmd_op_e op;
    logic                      ready_en;   // Goes high the cycle after reset
    logic                      accept;

    always_comb
    begin
        case (i_cmd_data[pcie_cfg_cmd_pkg::CMD_OP_LSB +: 2])
            pcie_cfg_cmd_pkg::OP_READ:  op = pcie_cfg_cmd_pkg::OP_READ;
            pcie_cfg_cmd_pkg::OP_WRITE: op = pcie_cfg_cmd_pkg::OP_WRITE;
            default:                    op = pcie_cfg_cmd_pkg::OP_NONE;
        endcase
    end

    assign o_reg_addr  = i_cmd_data[pcie_cfg_cmd_pkg::CMD_ADDR_LSB +: 16];
    assign o_reg_mask  = i_cmd_data[pcie_cfg_cmd_pkg::CMD_MASK_LSB +: 16];
    assign o_reg_value = i_cmd_data[pcie_cfg_cmd_pkg::CMD_VALUE_LSB +: 16];

    // Stall on a pending response or while waiting for the sequencer
    assign o_cmd_ready = ready_en & ~o_rsp_valid & ~(i_wait_complete & i_seq_busy);
    assign accept      = i_cmd_valid & o_cmd_ready;

    // Writes to the status region are dropped
    assign o_reg_wr = accept && (op == pcie_cfg_cmd_pkg::OP_WRITE)
                      && o_reg_addr[pcie_cfg_cmd_pkg::ADDR_RW_BIT];

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            ready_en    <= 1'b0;
            o_rsp_valid <= 1'b0;
        end
        else
        begin
            ready_en <= 1'b1;
            if (accept && (op == pcie_cfg_cmd_pkg::OP_READ))
                o_rsp_valid <= 1'b1;
            else if (i_rsp_ready)
                o_rsp_valid <= 1'b0;   // Host took it
        end
    end

    // Response payload, read data as it was at acceptance
    always_ff @(posedge clk_pcie)
    begin
        if (accept && (op == pcie_cfg_cmd_pkg::OP_READ))
        begin
            o_rsp_data[pcie_cfg_cmd_pkg::RSP_ADDR_LSB +: 16] <= o_reg_addr;
            o_rsp_data[pcie_cfg_cmd_pkg::RSP_DATA_LSB +: 16] <= i_reg_rdata;
        end
    end

endmodule

// File: logic/cfg_reg_file.sv
module cfg_reg_file #(
    parameter logic [31:0] CLR_PERIOD_RESET = 32'd62500
) (
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        i_reg_wr,
    input  logic [15:0] i_reg_addr,
    input  logic [15:0] i_reg_mask,
    input  logic [15:0] i_reg_value,
    output logic [15:0] o_reg_rdata,
    input  logic [7:0]  i_bus_number,
    input  logic [4:0]  i_device_number,
    input  logic [2:0]  i_function_number,
    input  logic [1:0]  i_busy,
    input  logic        i_rd_valid,
    input  logic [9:0]  i_rd_addr,
    input  logic [3:0]  i_rd_byte_en,
    input  logic [31:0] i_rd_data,
    output logic        o_rd_start,
    output logic        o_wr_start,
    output logic [31:0] o_mgmt_di,
    output logic [15:0] o_mgmt_addr_word,
    output logic        o_wait_complete,
    output logic        o_status_cl_en,
    output logic        o_command_en,
    output logic [31:0] o_clr_period,
    output logic [15:0] o_pcie_id
);

    localparam int RW_WORDS = pcie_cfg_regmap_pkg::RW_BYTES / 2;
    localparam int RO_WORDS = pcie_cfg_regmap_pkg::RO_BYTES / 2;
    localparam int W_CTRL   = pcie_cfg_regmap_pkg::OFS_CTRL / 2;

    logic [15:0] rw_q [RW_WORDS];
    logic [15:0] ro_w [RO_WORDS];
    logic [2:0]  word_idx;
    logic        in_rw;
    logic        in_ro;

    assign word_idx = i_reg_addr[3:1];
    assign in_rw    = i_reg_addr[14:0] < pcie_cfg_regmap_pkg::RW_BYTES;
    assign in_ro    = i_reg_addr[14:0] < pcie_cfg_regmap_pkg::RO_BYTES;

    // ------------------------------
    // Control region
    // ------------------------------
    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            rw_q[0]                                       <= pcie_cfg_regmap_pkg::RW_MAGIC;
            rw_q[W_CTRL]                                  <= '0;
            rw_q[pcie_cfg_regmap_pkg::OFS_MGMT_DI_LO / 2] <= '0;
            rw_q[pcie_cfg_regmap_pkg::OFS_MGMT_DI_HI / 2] <= '0;
            rw_q[pcie_cfg_regmap_pkg::OFS_MGMT_ADDR / 2]  <= pcie_cfg_regmap_pkg::MGMT_ADDR_RESET;
            rw_q[pcie_cfg_regmap_pkg::OFS_CLR_PERIOD_LO / 2] <= CLR_PERIOD_RESET[15:0];
            rw_q[pcie_cfg_regmap_pkg::OFS_CLR_PERIOD_HI / 2] <= CLR_PERIOD_RESET[31:16];
        end
        else
        begin
            // Start bits live for one cycle only
            rw_q[W_CTRL][pcie_cfg_regmap_pkg::CTRL_RD_START] <= 1'b0;
            rw_q[W_CTRL][pcie_cfg_regmap_pkg::CTRL_WR_START] <= 1'b0;
            if (i_reg_wr && in_rw)
                rw_q[word_idx] <= (rw_q[word_idx] & ~i_reg_mask) | (i_reg_value & i_reg_mask);
        end
    end

    assign o_rd_start       = rw_q[W_CTRL][pcie_cfg_regmap_pkg::CTRL_RD_START];
    assign o_wr_start       = rw_q[W_CTRL][pcie_cfg_regmap_pkg::CTRL_WR_START];
    assign o_wait_complete  = rw_q[W_CTRL][pcie_cfg_regmap_pkg::CTRL_WAIT_COMPLETE];
    assign o_status_cl_en   = rw_q[W_CTRL][pcie_cfg_regmap_pkg::CTRL_STATUS_CL_EN];
    assign o_command_en     = rw_q[W_CTRL][pcie_cfg_regmap_pkg::CTRL_COMMAND_EN];
    assign o_mgmt_di        = {rw_q[pcie_cfg_regmap_pkg::OFS_MGMT_DI_HI / 2],
                               rw_q[pcie_cfg_regmap_pkg::OFS_MGMT_DI_LO / 2]};
    assign o_mgmt_addr_word = rw_q[pcie_cfg_regmap_pkg::OFS_MGMT_ADDR / 2];
    assign o_clr_period     = {rw_q[pcie_cfg_regmap_pkg::OFS_CLR_PERIOD_HI / 2],
                               rw_q[pcie_cfg_regmap_pkg::OFS_CLR_PERIOD_LO / 2]};

    // ------------------------------
    // Status region
    // ------------------------------
    assign o_pcie_id = {i_bus_number, i_device_number, i_function_number};

    assign ro_w[0]                                       = pcie_cfg_regmap_pkg::RO_MAGIC;
    assign ro_w[pcie_cfg_regmap_pkg::OFS_PCIE_ID / 2]    = o_pcie_id;
    // Byte enables, valid, spare bit, dword address
    assign ro_w[pcie_cfg_regmap_pkg::OFS_RD_INFO / 2]    = {i_rd_byte_en, i_rd_valid, 1'b0,
                                                            i_rd_addr};
    assign ro_w[pcie_cfg_regmap_pkg::OFS_RD_DATA_LO / 2] = i_rd_data[15:0];
    assign ro_w[pcie_cfg_regmap_pkg::OFS_RD_DATA_HI / 2] = i_rd_data[31:16];
    assign ro_w[pcie_cfg_regmap_pkg::OFS_BUSY / 2]       = {14'd0, i_busy};

    // Out of range reads give zero
    always_comb
    begin
        o_reg_rdata = '0;
        if (i_reg_addr[pcie_cfg_cmd_pkg::ADDR_RW_BIT])
        begin
            if (in_rw)
                o_reg_rdata = rw_q[word_idx];
        end
        else if (in_ro)
        begin
            o_reg_rdata = ro_w[word_idx];
        end
    end

endmodule

// File: logic/cfg_mgmt_seq.sv
module cfg_mgmt_seq #(
    parameter int DWADDR_W = 10
) (
    input  logic                clk_pcie,
    input  logic                rst,
    input  logic                i_rd_start,
    input  logic                i_wr_start,
    input  logic [31:0]         i_mgmt_di,
    input  logic [15:0]         i_mgmt_addr_word,
    input  logic                i_clr_req,
    input  logic [3:0]          i_clr_byte_en,
    output logic                o_clr_ack,
    output logic                o_seq_busy,
    output logic [1:0]          o_busy,
    output logic                o_rd_valid,
    output logic [DWADDR_W-1:0] o_rd_addr,
    output logic [3:0]          o_rd_byte_en,
    output logic [31:0]         o_rd_data,
    output logic                o_mgmt_rd_en,
    output logic                o_mgmt_wr_en,
    output logic [31:0]         o_mgmt_di,
    output logic [DWADDR_W-1:0] o_mgmt_dwaddr,
    output logic [3:0]          o_mgmt_byte_en,
    output logic                o_mgmt_wr_readonly,
    output logic                o_mgmt_wr_rw1c_as_rw,
    input  logic                i_mgmt_done,
    input  logic [31:0]         i_mgmt_do
);

    pcie_cfg_regmap_pkg::mgmt_state_e state;
    logic                             rd_pend;   // Start seen while busy
    logic                             wr_pend;
    logic                             want_rd;
    logic                             want_wr;
    logic                             idle;

    assign idle    = state == pcie_cfg_regmap_pkg::IDLE;
    assign want_rd = rd_pend | i_rd_start;
    assign want_wr = wr_pend | i_wr_start;

    // Host starts win over the timer
    assign o_clr_ack  = idle & ~want_rd & ~want_wr & i_clr_req;
    assign o_seq_busy = ~idle | want_rd | want_wr;
    assign o_busy     = {o_mgmt_wr_en, o_mgmt_rd_en};

    // Enables drop in the done cycle
    assign o_mgmt_rd_en = (state == pcie_cfg_regmap_pkg::READ) & ~i_mgmt_done;
    assign o_mgmt_wr_en = (state == pcie_cfg_regmap_pkg::WRITE) & ~i_mgmt_done;

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            state      <= pcie_cfg_regmap_pkg::IDLE;
            rd_pend    <= 1'b0;
            wr_pend    <= 1'b0;
            o_rd_valid <= 1'b0;
        end
        else
        begin
            if (i_rd_start)
                rd_pend <= 1'b1;
            if (i_wr_start)
                wr_pend <= 1'b1;
            if (idle)
            begin
                if (want_rd)
                begin
                    state      <= pcie_cfg_regmap_pkg::READ;
                    rd_pend    <= 1'b0;
                    o_rd_valid <= 1'b0;
                end
                else if (want_wr || o_clr_ack)
                begin
                    state      <= pcie_cfg_regmap_pkg::WRITE;
                    wr_pend    <= 1'b0;   // Already zero for a timer write
                    o_rd_valid <= 1'b0;
                end
            end
            else if (i_mgmt_done)
            begin
                state      <= pcie_cfg_regmap_pkg::IDLE;
                o_rd_valid <= 1'b1;
            end
        end
    end

    // ------------------------------
    // Port fields and result capture
    // ------------------------------
    always_ff @(posedge clk_pcie)
    begin
        if (idle && (want_rd || want_wr))
        begin
            o_mgmt_di            <= i_mgmt_di;
            o_mgmt_dwaddr        <= i_mgmt_addr_word[DWADDR_W-1:0];
            o_mgmt_byte_en       <= i_mgmt_addr_word[pcie_cfg_regmap_pkg::ADDR_BE_LSB +: 4];
            o_mgmt_wr_readonly   <= i_mgmt_addr_word[pcie_cfg_regmap_pkg::ADDR_RDONLY_BIT];
            o_mgmt_wr_rw1c_as_rw <= i_mgmt_addr_word[pcie_cfg_regmap_pkg::ADDR_RW1C_BIT];
        end
        else if (o_clr_ack)
        begin
            o_mgmt_di            <= pcie_cfg_regmap_pkg::CLR_DATA;
            o_mgmt_dwaddr        <= DWADDR_W'(pcie_cfg_regmap_pkg::CLR_DWADDR);
            o_mgmt_byte_en       <= i_clr_byte_en;
            o_mgmt_wr_readonly   <= 1'b0;
            o_mgmt_wr_rw1c_as_rw <= 1'b0;
        end
        else if (!idle && i_mgmt_done)
        begin
            o_rd_addr    <= o_mgmt_dwaddr;
            o_rd_byte_en <= o_mgmt_byte_en;
            o_rd_data    <= i_mgmt_do;   // Also taken on writes
        end
    end

endmodule

// File: logic/cfg_status_clear.sv
module cfg_status_clear #(
    parameter int TIMER_W = 32
) (
    input  logic               clk_pcie,
    input  logic               rst,
    input  logic               i_status_cl_en,
    input  logic               i_command_en,
    input  logic [TIMER_W-1:0] i_period,
    input  logic               i_seq_busy,
    input  logic               i_clr_ack,
    output logic               o_clr_req,
    output logic [3:0]         o_clr_byte_en
);

    logic [TIMER_W-1:0] count;

    // Status bytes 3, command bytes 1..0
    assign o_clr_byte_en = {i_status_cl_en, 1'b0, i_command_en, i_command_en};

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            count     <= '0;
            o_clr_req <= 1'b0;
        end
        else if (o_clr_req)
        begin
            if (i_clr_ack)
                o_clr_req <= 1'b0;   // Sequencer has taken it
        end
        else if ((i_status_cl_en || i_command_en) && !i_seq_busy)
        begin
            if (count >= i_period)
            begin
                count     <= '0;
                o_clr_req <= 1'b1;
            end
            else
            begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// File: logic/pcie_cfg_top.sv
module pcie_cfg_top #(
    parameter int          DWADDR_W         = 10,
    parameter int          TIMER_W          = 32,
    parameter logic [31:0] CLR_PERIOD_RESET = 32'd62500   // 1 ms at 62.5 MHz
) (
    input  logic                clk_pcie,
    input  logic                rst,
    input  logic                i_cmd_valid,
    input  logic [63:0]         i_cmd_data,
    output logic                o_cmd_ready,
    output logic                o_rsp_valid,
    output logic [31:0]         o_rsp_data,
    input  logic                i_rsp_ready,
    input  logic [7:0]          i_bus_number,
    input  logic [4:0]          i_device_number,
    input  logic [2:0]          i_function_number,
    output logic                o_mgmt_rd_en,
    output logic                o_mgmt_wr_en,
    output logic [31:0]         o_mgmt_di,
    output logic [DWADDR_W-1:0] o_mgmt_dwaddr,
    output logic [3:0]          o_mgmt_byte_en,
    output logic                o_mgmt_wr_readonly,
    output logic                o_mgmt_wr_rw1c_as_rw,
    input  logic                i_mgmt_done,
    input  logic [31:0]         i_mgmt_do,
    output logic [15:0]         o_pcie_id
);

    // Decoder to register file
    logic        reg_wr;
    logic [15:0] reg_addr, reg_mask, reg_value, reg_rdata;

    // Register file to sequencer and timer
    logic                wait_complete, status_cl_en, command_en;
    logic                rd_start, wr_start;
    logic [31:0]         mgmt_di_word;
    logic [15:0]         mgmt_addr_word;
    logic [31:0]         clr_period;

    // Sequencer results
    logic                seq_busy, rd_valid;
    logic [1:0]          busy;
    logic [DWADDR_W-1:0] rd_addr;
    logic [3:0]          rd_byte_en;
    logic [31:0]         rd_data;

    // Timer handshake
    logic                clr_req, clr_ack;
    logic [3:0]          clr_byte_en;

    cfg_cmd_decoder u_decoder (
        .clk_pcie, .rst, .i_cmd_valid, .i_cmd_data, .o_cmd_ready,
        .o_rsp_valid, .o_rsp_data, .i_rsp_ready,
        .o_reg_wr(reg_wr), .o_reg_addr(reg_addr), .o_reg_mask(reg_mask),
        .o_reg_value(reg_value), .i_reg_rdata(reg_rdata),
        .i_wait_complete(wait_complete), .i_seq_busy(seq_busy)
    );

    cfg_reg_file #(.CLR_PERIOD_RESET(CLR_PERIOD_RESET)) u_reg_file (
        .clk_pcie, .rst,
        .i_reg_wr(reg_wr), .i_reg_addr(reg_addr), .i_reg_mask(reg_mask),
        .i_reg_value(reg_value), .o_reg_rdata(reg_rdata),
        .i_bus_number, .i_device_number, .i_function_number,
        .i_busy(busy), .i_rd_valid(rd_valid), .i_rd_addr(rd_addr),
        .i_rd_byte_en(rd_byte_en), .i_rd_data(rd_data),
        .o_rd_start(rd_start), .o_wr_start(wr_start),
        .o_mgmt_di(mgmt_di_word), .o_mgmt_addr_word(mgmt_addr_word),
        .o_wait_complete(wait_complete), .o_status_cl_en(status_cl_en),
        .o_command_en(command_en), .o_clr_period(clr_period), .o_pcie_id
    );

    cfg_mgmt_seq #(.DWADDR_W(DWADDR_W)) u_mgmt_seq (
        .clk_pcie, .rst,
        .i_rd_start(rd_start), .i_wr_start(wr_start),
        .i_mgmt_di(mgmt_di_word), .i_mgmt_addr_word(mgmt_addr_word),
        .i_clr_req(clr_req), .i_clr_byte_en(clr_byte_en), .o_clr_ack(clr_ack),
        .o_seq_busy(seq_busy), .o_busy(busy), .o_rd_valid(rd_valid),
        .o_rd_addr(rd_addr), .o_rd_byte_en(rd_byte_en), .o_rd_data(rd_data),
        .o_mgmt_rd_en, .o_mgmt_wr_en, .o_mgmt_di, .o_mgmt_dwaddr, .o_mgmt_byte_en,
        .o_mgmt_wr_readonly, .o_mgmt_wr_rw1c_as_rw, .i_mgmt_done, .i_mgmt_do
    );

    cfg_status_clear #(.TIMER_W(TIMER_W)) u_status_clear (
        .clk_pcie, .rst,
        .i_status_cl_en(status_cl_en), .i_command_en(command_en),
        .i_period(clr_period), .i_seq_busy(seq_busy), .i_clr_ack(clr_ack),
        .o_clr_req(clr_req), .o_clr_byte_en(clr_byte_en)
    );

endmodule

// File: bench/pcie_cfg_chk.sv
module pcie_cfg_chk (
    input logic        clk_pcie,
    input logic        rst,
    input logic        i_cmd_valid,
    input logic [63:0] i_cmd_data,
    input logic        o_cmd_ready,
    input logic        o_rsp_valid,
    input logic [31:0] o_rsp_data,
    input logic        i_rsp_ready,
    input logic        o_mgmt_rd_en,
    input logic        o_mgmt_wr_en,
    input logic        i_mgmt_done
);

    // Valid and payload hold until the transfer
    a_cmd_hold: assert property (@(posedge clk_pcie) disable iff (rst)
        i_cmd_valid && !o_cmd_ready |=> i_cmd_valid && $stable(i_cmd_data))
        else $error("command valid dropped before ready");

    a_rsp_hold: assert property (@(posedge clk_pcie) disable iff (rst)
        o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp_data))
        else $error("response valid dropped before ready");

    a_one_enable: assert property (@(posedge clk_pcie) disable iff (rst)
        !(o_mgmt_rd_en && o_mgmt_wr_en))
        else $error("read and write enables both high");

    // Enable holds until done, low in the done cycle
    a_done_mask: assert property (@(posedge clk_pcie) disable iff (rst)
        (o_mgmt_rd_en || o_mgmt_wr_en) |=>
            (i_mgmt_done ? !(o_mgmt_rd_en || o_mgmt_wr_en)
                         : ($stable(o_mgmt_rd_en) && $stable(o_mgmt_wr_en))))
        else $error("enable dropped before done or high in the done cycle");

endmodule

bind pcie_cfg_top pcie_cfg_chk u_chk (.*);

// File: bench/pcie_cfg_tb.sv
module pcie_cfg_tb;

    localparam int TMO = 2000;   // Cycles allowed for any wait

    logic        clk_pcie = 1'b0;
    logic        rst = 1'b1;
    logic        i_cmd_valid = 1'b0;
    logic [63:0] i_cmd_data = '0;
    logic        i_rsp_ready = 1'b1;
    logic        i_mgmt_done = 1'b0;
    logic [31:0] i_mgmt_do = '0;
    logic        o_cmd_ready, o_rsp_valid, o_mgmt_rd_en, o_mgmt_wr_en;
    logic        o_mgmt_wr_readonly, o_mgmt_wr_rw1c_as_rw;
    logic [31:0] o_rsp_data, o_mgmt_di;
    logic [9:0]  o_mgmt_dwaddr;
    logic [3:0]  o_mgmt_byte_en;
    logic [15:0] o_pcie_id;

    // Reference state: control words plus last access seen on the port
    logic [15:0] ctrl_model [7] = '{16'h6745, 16'h0, 16'h0, 16'h0, 16'hF000, 16'hF424, 16'h0};
    logic [9:0]  la_addr = '0;
    logic [3:0]  la_be = '0;
    logic [31:0] la_data = '0;
    logic        la_valid = 1'b0;
    logic        mgmt_active = 1'b0;
    int          mgmt_reads = 0, mgmt_writes = 0;
    logic [31:0] wr_data_q[$];
    logic [15:0] wr_info_q[$];   // {be, rw1c, readonly, dwaddr}
    logic [31:0] exp_q[$];
    logic [31:0] host_rng = 32'ha4bc156a, mgmt_rng = 32'ha4bc156a, stall_rng = 32'ha4bc156a;
    logic        stall_en = 1'b0;
    int          errors = 0, err_mark = 0, tests_ok = 0, tests_bad = 0, rsp_count = 0;

    pcie_cfg_top DUT (.*, .i_bus_number(8'h3C), .i_device_number(5'h11),
                      .i_function_number(3'h5));

    always #2 clk_pcie = ~clk_pcie;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Expected 16-bit read data from the register map rules
    function automatic logic [15:0] ref_read(input logic [15:0] addr);
        if (addr[15])
            return (addr[14:0] < 14) ? ctrl_model[addr[3:1]] : 16'h0;
        case (addr[14:0])
            15'h0:   return 16'h2301;
            15'h2:   return {8'h3C, 5'h11, 3'h5};
            15'h4:   return {la_be, la_valid, 1'b0, la_addr};
            15'h6:   return la_data[15:0];
            15'h8:   return la_data[31:16];
            default: return 16'h0;   // Busy reads zero when idle
        endcase
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s at time %0t", what, $time);
        errors++;
    endtask

    task automatic send_cmd(input logic [1:0] op, input logic [15:0] addr,
                            input logic [15:0] mask, input logic [15:0] value);
        int n;
        n = 0;
        @(negedge clk_pcie);
        i_cmd_valid = 1'b1;
        i_cmd_data  = {value, mask, addr, 2'b00, op, 12'h0};
        while (!o_cmd_ready && n < TMO)
        begin
            @(negedge clk_pcie);
            n++;
        end
        if (n >= TMO)
            report_timeout("command ready");
        @(negedge clk_pcie);
        i_cmd_valid = 1'b0;
    endtask

    task automatic do_write(input logic [15:0] addr, input logic [15:0] mask,
                            input logic [15:0] value);
        send_cmd(2'b10, addr, mask, value);
        if (addr[15] && addr[14:0] < 14)
            ctrl_model[addr[3:1]] = (ctrl_model[addr[3:1]] & ~mask) | (value & mask);
        ctrl_model[1][1:0] = 2'b00;   // Start bits self clear
    endtask

    task automatic do_read(input logic [15:0] addr);
        exp_q.push_back({addr, ref_read(addr)});
        send_cmd(2'b01, addr, 16'h0, 16'h0);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < TMO)
        begin
            @(negedge clk_pcie);
            n++;
        end
        if (n >= TMO)
            report_timeout("responses");
    endtask

    task automatic wait_access(input int target_reads, input int target_writes);
        int n;
        n = 0;
        while ((mgmt_reads < target_reads || mgmt_writes < target_writes || mgmt_active)
               && n < TMO)
        begin
            @(negedge clk_pcie);
            n++;
        end
        if (n >= TMO)
            report_timeout("management access");
    endtask

    task automatic end_test(input string name);
        drain();
        if (errors == err_mark)
        begin
            tests_ok++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // ------------------------------
    // Management port model
    // ------------------------------
    always
    begin
        @(posedge clk_pcie);
        if (!rst && (o_mgmt_rd_en || o_mgmt_wr_en))
        begin
            mgmt_active = 1'b1;
            la_addr     = o_mgmt_dwaddr;
            la_be       = o_mgmt_byte_en;
            if (o_mgmt_wr_en)
            begin
                mgmt_writes++;
                wr_data_q.push_back(o_mgmt_di);
                wr_info_q.push_back({o_mgmt_byte_en, o_mgmt_wr_rw1c_as_rw,
                                     o_mgmt_wr_readonly, o_mgmt_dwaddr});
            end
            else
                mgmt_reads++;
            mgmt_rng = xorshift(mgmt_rng);
            repeat (1 + mgmt_rng % 5) @(negedge clk_pcie);
            i_mgmt_do   = {22'h0, la_addr} ^ 32'hA5A50000;
            i_mgmt_done = 1'b1;
            la_data     = i_mgmt_do;
            la_valid    = 1'b1;
            @(negedge clk_pcie);
            i_mgmt_done = 1'b0;
            mgmt_active = 1'b0;
        end
    end

    always @(negedge clk_pcie)
    begin
        stall_rng   = xorshift(stall_rng);
        i_rsp_ready = !stall_en || stall_rng[0] || stall_rng[1];   // Random host stall
    end

    // Response comparison, in command order
    always @(posedge clk_pcie)
    begin
        if (!rst && o_rsp_valid && i_rsp_ready)
        begin
            rsp_count++;
            if (exp_q.size() == 0)
            begin
                $display("response %h arrived with no read outstanding at %0t",
                         o_rsp_data, $time);
                errors++;
            end
            else if (o_rsp_data !== exp_q[0])
            begin
                $display("CHECK FAILED t=%0t o_rsp_data exp=%h got=%h",
                         $time, exp_q[0], o_rsp_data);
                errors++;
                void'(exp_q.pop_front());
            end
            else
                void'(exp_q.pop_front());
        end
    end

    initial
    begin
        logic [15:0] a, v, w;
        int          base_r, base_w, rsp_base;
        repeat (4) @(posedge clk_pcie);
        @(negedge clk_pcie);
        rst = 1'b0;

        // Reset values and range checks
        do_read(16'h8000);
        do_read(16'h0000);
        do_read(16'h0002);
        do_read(16'h800E);
        do_read(16'h000C);
        do_read(16'h801E);
        if (o_pcie_id !== {8'h3C, 5'h11, 3'h5})
        begin
            $display("CHECK FAILED t=%0t o_pcie_id exp=%h got=%h",
                     $time, {8'h3C, 5'h11, 3'h5}, o_pcie_id);
            errors++;
        end
        end_test("reset_values");

        // Random masked writes, timer and start bits kept off
        for (int i = 0; i < 24; i++)
        begin
            host_rng = xorshift(host_rng);
            a = {!(i % 5 == 4), 11'h0, host_rng[3:1], 1'b0};
            w = (a[3:1] == 3'd1) ? 16'hFFC8 : 16'hFFFF;
            v = host_rng[31:16];
            do_write(a, host_rng[15:0] & w, v);
            do_read(a | 16'h8000);
        end
        end_test("masked_writes");

        // Management read
        host_rng = xorshift(host_rng);
        base_r = mgmt_reads;
        do_write(16'h8008, 16'hFFFF, {4'b0110, 2'b00, host_rng[9:0]});
        do_write(16'h8002, 16'h0001, 16'h0001);
        wait_access(base_r + 1, mgmt_writes);
        if (mgmt_reads != base_r + 1)
        begin
            $display("expected one management read, saw %0d", mgmt_reads - base_r);
            errors++;
        end
        if (la_addr !== host_rng[9:0])
        begin
            $display("CHECK FAILED t=%0t o_mgmt_dwaddr exp=%h got=%h",
                     $time, host_rng[9:0], la_addr);
            errors++;
        end
        if (la_be !== 4'b0110)
        begin
            $display("CHECK FAILED t=%0t o_mgmt_byte_en exp=%h got=%h",
                     $time, 4'b0110, la_be);
            errors++;
        end
        do_read(16'h000A);
        do_read(16'h0004);
        do_read(16'h0006);
        do_read(16'h0008);
        end_test("mgmt_read");

        // Management write
        host_rng = xorshift(host_rng);
        base_w = mgmt_writes;
        do_write(16'h8004, 16'hFFFF, host_rng[15:0]);
        do_write(16'h8006, 16'hFFFF, host_rng[31:16]);
        do_write(16'h8008, 16'hFFFF, {4'b1001, 2'b01, 10'h155});
        do_write(16'h8002, 16'h0002, 16'h0002);
        wait_access(mgmt_reads, base_w + 1);
        if (mgmt_writes != base_w + 1 || wr_data_q[$] !== host_rng)
        begin
            $display("CHECK FAILED t=%0t o_mgmt_di exp=%h got=%h", $time, host_rng, wr_data_q[$]);
            errors++;
        end
        if (wr_info_q[$] !== {4'b1001, 2'b01, 10'h155})
        begin
            $display("CHECK FAILED t=%0t o_mgmt_fields exp=%h got=%h",
                     $time, {4'b1001, 2'b01, 10'h155}, wr_info_q[$]);
            errors++;
        end
        end_test("mgmt_write");

        // Back-pressure on responses
        stall_en = 1'b1;
        rsp_base = rsp_count;
        for (int i = 0; i < 30; i++)
        begin
            host_rng = xorshift(host_rng);
            do_read({1'b1, 11'h0, host_rng[3:1], 1'b0});
        end
        drain();
        if (rsp_count - rsp_base != 30)
        begin
            $display("expected 30 responses under back-pressure, saw %0d", rsp_count - rsp_base);
            errors++;
        end
        end_test("backpressure");
        stall_en = 1'b0;

        // Periodic status-clear writes
        base_w = mgmt_writes;
        do_write(16'h800A, 16'hFFFF, 16'h0003);
        do_write(16'h800C, 16'hFFFF, 16'h0000);
        do_write(16'h8002, 16'h0030, 16'h0030);
        wait_access(mgmt_reads, base_w + 2);
        do_write(16'h8002, 16'h0030, 16'h0000);
        repeat (12) @(negedge clk_pcie);
        wait_access(mgmt_reads, base_w);
        for (int i = base_w; i < mgmt_writes; i++)
        begin
            if (wr_data_q[i] !== 32'hFF000007)
            begin
                $display("CHECK FAILED t=%0t o_mgmt_di exp=%h got=%h",
                         $time, 32'hFF000007, wr_data_q[i]);
                errors++;
            end
            if (wr_info_q[i] !== {4'b1011, 2'b00, 10'h001})
            begin
                $display("CHECK FAILED t=%0t o_mgmt_fields exp=%h got=%h",
                         $time, {4'b1011, 2'b00, 10'h001}, wr_info_q[i]);
                errors++;
            end
        end
        end_test("status_clear");

        $display("tests passed %0d, tests failed %0d", tests_ok, tests_bad);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: filelist.f
logic/pcie_cfg_regmap_pkg.sv
logic/pcie_cfg_cmd_pkg.sv
logic/cfg_cmd_decoder.sv
logic/cfg_reg_file.sv
logic/cfg_mgmt_seq.sv
logic/cfg_status_clear.sv
logic/pcie_cfg_top.sv
bench/pcie_cfg_chk.sv
bench/pcie_cfg_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module pcie_cfg_tb \
    -f filelist.f -o pcie_cfg_sim > build.log 2>&1 \
    && ./obj_dir/pcie_cfg_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
